/* had_pkg.sv */
`default_nettype none

package had_pkg;

  //========================================
  // Cluster and datapath sizes
  //========================================
  localparam int num_cores  = 4;
  localparam int core_idx_w = 2;
  localparam int data_w     = 64;
  localparam int reg_w      = 32;

  // IR layout with the register code in bits 3:0 and the core index in bits 5:4
  localparam int ir_w       = 8;
  localparam int reg_code_w = 4;

  //========================================
  // Register codes
  //========================================
  // Code 0 is left unused so a cleared IR selects nothing
  localparam logic [reg_code_w-1:0] reg_code_id   = 4'h1;
  localparam logic [reg_code_w-1:0] reg_code_rsr  = 4'h2;
  localparam logic [reg_code_w-1:0] reg_code_dms  = 4'h3;
  localparam logic [reg_code_w-1:0] reg_code_fifo = 4'h4;
  localparam logic [reg_code_w-1:0] reg_code_hcr  = 4'h5;

  //========================================
  // Debug ID word fields
  //========================================
  localparam logic [3:0] id_if_type   = 4'd0;
  localparam logic [1:0] id_arch      = 2'd2;
  localparam logic       id_rsr_en    = 1'b1;
  localparam logic       id_hcr_16b   = 1'b1;
  localparam logic       id_bank1     = 1'b0;
  localparam logic       id_ddc       = 1'b1;
  localparam logic [3:0] id_bkpt_num  = 4'd2;
  localparam logic [3:0] id_revision  = 4'd11;
  localparam logic [3:0] id_version   = 4'd4;
  localparam logic [3:0] id_id_ver    = 4'd3;

  // Bits 25:20 reserved and read as zero
  localparam logic [reg_w-1:0] had_id_value = {
    id_if_type, id_arch, 6'd0, id_rsr_en, id_hcr_16b, id_bank1, id_ddc,
    id_bkpt_num, id_revision, id_version, id_id_ver
  };

  //========================================
  // Halt control and debug FIFO
  //========================================
  localparam int hcr_w           = 16;
  localparam int hcr_dbg_req_bit = 0;

  localparam int fifo_depth = 4;
  localparam int fifo_ptr_w = $clog2(fifo_depth);
  localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

endpackage

`default_nettype wire

/* had_ir_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module had_ir_decode
  import had_pkg::*;
(
  input  wire                  forever_cpuclk,
  input  wire                  core0_rst_b,
  input  wire                  host_ir_wr,
  input  wire [ir_w-1:0]       host_ir,
  input  wire                  host_wr,
  input  wire                  host_rd,
  input  wire                  fifo_empty,
  output logic                 id_sel,
  output logic                 rsr_sel,
  output logic                 dms_sel,
  output logic                 fifo_sel,
  output logic                 hcr_sel,
  output logic [num_cores-1:0] core_sel,
  output logic [num_cores-1:0] hcr_wr,
  output logic                 fifo_push,
  output logic                 fifo_pop
);

  logic [ir_w-1:0]       ir_q;
  logic [reg_code_w-1:0] reg_code;
  logic [core_idx_w-1:0] core_idx;

  //========================================
  // Instruction register
  //========================================
  always_ff @(posedge forever_cpuclk or negedge core0_rst_b)
  begin
    if (!core0_rst_b)
      ir_q <= '0;
    else if (host_ir_wr)
      ir_q <= host_ir;
  end

  // Field split
  assign reg_code = ir_q[reg_code_w-1:0];
  assign core_idx = ir_q[reg_code_w +: core_idx_w];

  //========================================
  // Register and core selects
  //========================================
  // Level selects held until the next IR load
  assign id_sel   = (reg_code == reg_code_id);
  assign rsr_sel  = (reg_code == reg_code_rsr);
  assign dms_sel  = (reg_code == reg_code_dms);
  assign fifo_sel = (reg_code == reg_code_fifo);
  assign hcr_sel  = (reg_code == reg_code_hcr);

  // One-hot core select from the index field
  always_comb
  begin
    for (int i = 0; i < num_cores; i++)
    begin
      core_sel[i] = (core_idx == core_idx_w'(i));
    end
  end

  //========================================
  // Qualified host strobes
  //========================================
  // HCR write only reaches the selected core
  assign hcr_wr    = {num_cores{host_wr & hcr_sel}} & core_sel;
  assign fifo_push = host_wr & fifo_sel;
  // No pop on an empty FIFO so the read returns zero
  assign fifo_pop  = host_rd & fifo_sel & ~fifo_empty;

endmodule

`default_nettype wire

/* had_core_dbg.sv */
`timescale 1ns/1ps
`default_nettype none

module had_core_dbg
  import had_pkg::*;
(
  input  wire              forever_cpuclk,
  input  wire              core0_rst_b,
  input  wire              core_rst_b,
  input  wire              sysio_mask,
  input  wire              hcr_wr,
  input  wire [hcr_w-1:0]  wdata,
  output logic             core_rst_stat,
  output logic [hcr_w-1:0] hcr_data,
  output logic             dbg_req
);

  logic [hcr_w-1:0] hcr_q;
  logic             req_bit;

  //========================================
  // Reset status
  //========================================
  // Set while this core sits in reset
  // Cleared on the first clock after release
  always_ff @(posedge forever_cpuclk or negedge core_rst_b)
  begin
    if (!core_rst_b)
      core_rst_stat <= 1'b1;
    else
      core_rst_stat <= 1'b0;
  end

  //========================================
  // Halt control register
  //========================================
  always_ff @(posedge forever_cpuclk or negedge core0_rst_b)
  begin
    if (!core0_rst_b)
      hcr_q <= '0;
    else if (hcr_wr)
      hcr_q <= wdata;
  end

  assign hcr_data = hcr_q;

  // Debug request field
  assign req_bit = hcr_q[hcr_dbg_req_bit];

  //========================================
  // Debug request to the core
  //========================================
  // System mask blocks the request
  // Registered so it follows one cycle after an HCR or mask change
  always_ff @(posedge forever_cpuclk or negedge core0_rst_b)
  begin
    if (!core0_rst_b)
      dbg_req <= 1'b0;
    else
      dbg_req <= req_bit & ~sysio_mask;
  end

endmodule

`default_nettype wire

/* had_dbg_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module had_dbg_fifo
  import had_pkg::*;
(
  input  wire               forever_cpuclk,
  input  wire               core0_rst_b,
  input  wire               fifo_push,
  input  wire               fifo_pop,
  input  wire  [data_w-1:0] push_data,
  output logic [data_w-1:0] fifo_head,
  output logic              fifo_empty,
  output logic              fifo_full
);

  logic [data_w-1:0]     mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_cnt_w-1:0] count;
  logic                  do_push;
  logic                  do_pop;

  // Push when full is dropped
  assign do_push = fifo_push & ~fifo_full;
  // Pop arrives already qualified by not empty
  assign do_pop  = fifo_pop;

  //========================================
  // Storage
  //========================================
  always_ff @(posedge forever_cpuclk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  //========================================
  // Pointers and occupancy
  //========================================
  always_ff @(posedge forever_cpuclk or negedge core0_rst_b)
  begin
    if (!core0_rst_b)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // Wrap at the last slot
      if (do_push)
        wr_ptr <= (wr_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      // Simultaneous push and pop leaves the count alone
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  // Status flags
  assign fifo_empty = (count == '0);
  assign fifo_full  = (count == fifo_cnt_w'(fifo_depth));

  // Head reads as zero when nothing is stored
  assign fifo_head = fifo_empty ? '0 : mem[rd_ptr];

  a_no_pop_empty: assert property (
    @(posedge forever_cpuclk) disable iff (!core0_rst_b)
      !(fifo_pop && fifo_empty)
  ) else $error("had_dbg_fifo: pop on empty FIFO");

endmodule

`default_nettype wire

/* had_common_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module had_common_regs
  import had_pkg::*;
(
  input  wire                        forever_cpuclk,
  input  wire                        core0_rst_b,
  input  wire                        host_rd,
  input  wire                        id_sel,
  input  wire                        rsr_sel,
  input  wire                        dms_sel,
  input  wire                        fifo_sel,
  input  wire                        hcr_sel,
  input  wire  [num_cores-1:0]       core_sel,
  input  wire  [num_cores-1:0]       core_rst_stat,
  input  wire  [num_cores*hcr_w-1:0] hcr_data,
  input  wire  [num_cores-1:0]       sysio_dbg_mask,
  input  wire  [data_w-1:0]          fifo_head,
  output logic [data_w-1:0]          host_rdata,
  output logic                       host_rdata_vld,
  output logic [num_cores-1:0]       core_dbg_mask
);

  logic [reg_w-1:0]  rsr_word;
  logic [reg_w-1:0]  dms_word;
  logic [hcr_w-1:0]  hcr_pick;
  logic [data_w-1:0] rd_mux;

  //========================================
  // Status words
  //========================================
  // One bit per core with the upper bits zero
  assign rsr_word = {{(reg_w - num_cores){1'b0}}, core_rst_stat};
  assign dms_word = {{(reg_w - num_cores){1'b0}}, sysio_dbg_mask};

  // Mask goes straight through to the cores
  assign core_dbg_mask = sysio_dbg_mask;

  //========================================
  // HCR of the selected core
  //========================================
  always_comb
  begin
    hcr_pick = '0;
    for (int i = 0; i < num_cores; i++)
    begin
      hcr_pick = hcr_pick | ({hcr_w{core_sel[i]}} & hcr_data[i*hcr_w +: hcr_w]);
    end
  end

  //========================================
  // Read mux
  //========================================
  // AND-OR select where unknown codes give zero
  // 32-bit and HCR words are zero-extended
  assign rd_mux =
      ({data_w{id_sel}}   & {{(data_w - reg_w){1'b0}}, had_id_value})
    | ({data_w{rsr_sel}}  & {{(data_w - reg_w){1'b0}}, rsr_word})
    | ({data_w{dms_sel}}  & {{(data_w - reg_w){1'b0}}, dms_word})
    | ({data_w{fifo_sel}} & fifo_head)
    | ({data_w{hcr_sel}}  & {{(data_w - hcr_w){1'b0}}, hcr_pick});

  // Read data held until the next read
  always_ff @(posedge forever_cpuclk)
  begin
    if (host_rd)
      host_rdata <= rd_mux;
  end

  // One-cycle valid per read strobe
  always_ff @(posedge forever_cpuclk or negedge core0_rst_b)
  begin
    if (!core0_rst_b)
      host_rdata_vld <= 1'b0;
    else
      host_rdata_vld <= host_rd;
  end

endmodule

`default_nettype wire

/* had_top.sv */
`timescale 1ns/1ps
`default_nettype none

module had_top
  import had_pkg::*;
(
  input  wire                  forever_cpuclk,
  input  wire                  core0_rst_b,
  input  wire                  host_ir_wr,
  input  wire [ir_w-1:0]       host_ir,
  input  wire                  host_wr,
  input  wire                  host_rd,
  input  wire [data_w-1:0]     host_wdata,
  output wire [data_w-1:0]     host_rdata,
  output wire                  host_rdata_vld,
  input  wire [num_cores-1:0]  sysio_dbg_mask,
  input  wire [num_cores-1:0]  core_rst_b,
  output wire [num_cores-1:0]  core_dbg_mask,
  output wire [num_cores-1:0]  core_dbg_req
);

  // Decoder outputs
  wire                       id_sel;
  wire                       rsr_sel;
  wire                       dms_sel;
  wire                       fifo_sel;
  wire                       hcr_sel;
  wire [num_cores-1:0]       core_sel;
  wire [num_cores-1:0]       hcr_wr;
  wire                       fifo_push;
  wire                       fifo_pop;

  // Per-core status
  wire [num_cores-1:0]       core_rst_stat;
  wire [num_cores*hcr_w-1:0] hcr_data;

  // FIFO status
  wire [data_w-1:0]          fifo_head;
  wire                       fifo_empty;

  //========================================
  // IR and strobe decode
  //========================================
  had_ir_decode ir_dec_i (
    .forever_cpuclk (forever_cpuclk),
    .core0_rst_b    (core0_rst_b),
    .host_ir_wr     (host_ir_wr),
    .host_ir        (host_ir),
    .host_wr        (host_wr),
    .host_rd        (host_rd),
    .fifo_empty     (fifo_empty),
    .id_sel         (id_sel),
    .rsr_sel        (rsr_sel),
    .dms_sel        (dms_sel),
    .fifo_sel       (fifo_sel),
    .hcr_sel        (hcr_sel),
    .core_sel       (core_sel),
    .hcr_wr         (hcr_wr),
    .fifo_push      (fifo_push),
    .fifo_pop       (fifo_pop)
  );

  //========================================
  // Per-core debug blocks
  //========================================
  for (genvar i = 0; i < num_cores; i++)
  begin : g_core
    had_core_dbg core_dbg_i (
      .forever_cpuclk (forever_cpuclk),
      .core0_rst_b    (core0_rst_b),
      .core_rst_b     (core_rst_b[i]),
      .sysio_mask     (sysio_dbg_mask[i]),
      .hcr_wr         (hcr_wr[i]),
      .wdata          (host_wdata[hcr_w-1:0]),
      .core_rst_stat  (core_rst_stat[i]),
      .hcr_data       (hcr_data[i*hcr_w +: hcr_w]),
      .dbg_req        (core_dbg_req[i])
    );
  end

  // Host data FIFO
  had_dbg_fifo dbg_fifo_i (
    .forever_cpuclk (forever_cpuclk),
    .core0_rst_b    (core0_rst_b),
    .fifo_push      (fifo_push),
    .fifo_pop       (fifo_pop),
    .push_data      (host_wdata),
    .fifo_head      (fifo_head),
    .fifo_empty     (fifo_empty),
    .fifo_full      ()
  );

  // Read mux and registered read data
  had_common_regs common_regs_i (
    .forever_cpuclk (forever_cpuclk),
    .core0_rst_b    (core0_rst_b),
    .host_rd        (host_rd),
    .id_sel         (id_sel),
    .rsr_sel        (rsr_sel),
    .dms_sel        (dms_sel),
    .fifo_sel       (fifo_sel),
    .hcr_sel        (hcr_sel),
    .core_sel       (core_sel),
    .core_rst_stat  (core_rst_stat),
    .hcr_data       (hcr_data),
    .sysio_dbg_mask (sysio_dbg_mask),
    .fifo_head      (fifo_head),
    .host_rdata     (host_rdata),
    .host_rdata_vld (host_rdata_vld),
    .core_dbg_mask  (core_dbg_mask)
  );

endmodule

`default_nettype wire

/* tb_had_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_had_top
  import had_pkg::*;
();

  logic                 forever_cpuclk;
  logic                 core0_rst_b;
  logic                 host_ir_wr;
  logic [ir_w-1:0]      host_ir;
  logic                 host_wr;
  logic                 host_rd;
  logic [data_w-1:0]    host_wdata;
  wire  [data_w-1:0]    host_rdata;
  wire                  host_rdata_vld;
  logic [num_cores-1:0] sysio_dbg_mask;
  logic [num_cores-1:0] core_rst_b;
  wire  [num_cores-1:0] core_dbg_mask;
  wire  [num_cores-1:0] core_dbg_req;

  // Model state
  integer               seed;
  int                   fail_count;
  logic [ir_w-1:0]      ir_m;
  logic [num_cores-1:0] mask_m;
  logic [num_cores-1:0] stat_m;
  logic [hcr_w-1:0]     hcr_m [num_cores];
  logic [data_w-1:0]    fifo_m [$];

  // Captured at the read edge
  logic                 rd_cap;
  logic [data_w-1:0]    rdata_exp;
  logic [num_cores-1:0] req_exp;

  had_top dut_i (
    .forever_cpuclk (forever_cpuclk),
    .core0_rst_b    (core0_rst_b),
    .host_ir_wr     (host_ir_wr),
    .host_ir        (host_ir),
    .host_wr        (host_wr),
    .host_rd        (host_rd),
    .host_wdata     (host_wdata),
    .host_rdata     (host_rdata),
    .host_rdata_vld (host_rdata_vld),
    .sysio_dbg_mask (sysio_dbg_mask),
    .core_rst_b     (core_rst_b),
    .core_dbg_mask  (core_dbg_mask),
    .core_dbg_req   (core_dbg_req)
  );

  // 40 ns clock
  initial
  begin
    forever_cpuclk = 1'b0;
    forever #20 forever_cpuclk = ~forever_cpuclk;
  end

  //========================================
  // Reference model
  //========================================
  // Expected read data for an IR value
  function automatic logic [data_w-1:0] expected_rdata(input logic [ir_w-1:0] ir);
    logic [reg_code_w-1:0] code;
    int                    core;
    logic [data_w-1:0]     res;
    code = ir[reg_code_w-1:0];
    core = int'(ir[reg_code_w +: core_idx_w]);
    res  = '0;
    case (code)
      reg_code_id:   res[reg_w-1:0] = had_id_value;
      reg_code_rsr:  res[num_cores-1:0] = stat_m;
      reg_code_dms:  res[num_cores-1:0] = mask_m;
      reg_code_fifo:
      begin
        // Empty FIFO reads zero
        if (fifo_m.size() > 0)
          res = fifo_m[0];
      end
      reg_code_hcr:  res[hcr_w-1:0] = hcr_m[core];
      default:       res = '0;
    endcase
    return res;
  endfunction

  // Request bit blocked by the mask
  function automatic logic [num_cores-1:0] expected_req();
    logic [num_cores-1:0] r;
    for (int i = 0; i < num_cores; i++)
      r[i] = hcr_m[i][hcr_dbg_req_bit] & ~mask_m[i];
    return r;
  endfunction

  function automatic logic [data_w-1:0] random_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  //========================================
  // Checks and host tasks
  //========================================
  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [data_w-1:0] got,
                             input logic [data_w-1:0] exp);
    if (got !== exp)
    begin
      fail_count++;
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
      abort_run();
    end
  endtask

  // Inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge forever_cpuclk);
    #2;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic load_ir(input logic [reg_code_w-1:0] code, input int core);
    host_ir = '0;
    host_ir[reg_code_w-1:0] = code;
    host_ir[reg_code_w +: core_idx_w] = core_idx_w'(core);
    host_ir_wr = 1'b1;
    next_cycle();
    host_ir_wr = 1'b0;
    ir_m = host_ir;
  endtask

  task automatic host_write(input logic [data_w-1:0] data);
    logic [reg_code_w-1:0] code;
    int                    core;
    host_wdata = data;
    host_wr    = 1'b1;
    next_cycle();
    host_wr = 1'b0;
    code = ir_m[reg_code_w-1:0];
    core = int'(ir_m[reg_code_w +: core_idx_w]);
    // HCR keeps the low bits and a full FIFO drops the word
    if (code == reg_code_hcr)
      hcr_m[core] = data[hcr_w-1:0];
    else if (code == reg_code_fifo && fifo_m.size() < fifo_depth)
      fifo_m.push_back(data);
  endtask

  task automatic host_read();
    int waited;
    host_rd = 1'b1;
    next_cycle();
    host_rd = 1'b0;
    // Head leaves at the read edge
    if (ir_m[reg_code_w-1:0] == reg_code_fifo && fifo_m.size() > 0)
      void'(fifo_m.pop_front());
    waited = 0;
    while (host_rdata_vld !== 1'b1)
    begin
      if (waited >= 4)
      begin
        $display("Timeout: no host_rdata_vld after a host read");
        abort_run();
      end
      else
      begin
        next_cycle();
        waited++;
      end
    end
  endtask

  //========================================
  // Comparing process
  //========================================
  // Expectation taken at the edge and outputs checked mid-cycle
  initial
  begin
    rd_cap    = 1'b0;
    rdata_exp = '0;
    req_exp   = '0;
    forever
    begin
      @(posedge forever_cpuclk);
      rd_cap    = host_rd;
      rdata_exp = expected_rdata(ir_m);
      req_exp   = expected_req();
      @(negedge forever_cpuclk);
      if (core0_rst_b === 1'b1)
      begin
        check_value("host_rdata_vld", data_w'(host_rdata_vld), data_w'(rd_cap));
        if (rd_cap)
          check_value("host_rdata", host_rdata, rdata_exp);
        check_value("core_dbg_req", data_w'(core_dbg_req), data_w'(req_exp));
        check_value("core_dbg_mask", data_w'(core_dbg_mask), data_w'(mask_m));
      end
    end
  end

  //========================================
  // Tests
  //========================================
  task automatic test_id();
    load_ir(reg_code_id, 0);
    host_read();
    // Valid must drop again
    idle_cycles(2);
    // Unused codes read zero
    load_ir('0, 0);
    host_read();
    for (int c = 6; c < 16; c++)
    begin
      load_ir(reg_code_w'(c), c % num_cores);
      host_read();
    end
  endtask

  task automatic test_rst_status();
    logic [31:0]          r;
    logic [num_cores-1:0] held;
    load_ir(reg_code_rsr, 0);
    repeat (6)
    begin
      r    = $random(seed);
      held = r[num_cores-1:0];
      core_rst_b = ~held;
      stat_m     = held;
      idle_cycles(1);
      host_read();
      // Status clears on the edge after release
      core_rst_b = '1;
      next_cycle();
      stat_m = '0;
      host_read();
    end
  endtask

  task automatic test_mask();
    logic [31:0] r;
    load_ir(reg_code_dms, 0);
    repeat (8)
    begin
      r = $random(seed);
      sysio_dbg_mask = r[num_cores-1:0];
      mask_m         = r[num_cores-1:0];
      // Combinational path to the cores
      #1;
      check_value("core_dbg_mask", data_w'(core_dbg_mask), data_w'(mask_m));
      host_read();
    end
  endtask

  task automatic test_fifo();
    load_ir(reg_code_fifo, 0);
    host_read();
    // Two words past depth are dropped
    repeat (fifo_depth + 2)
      host_write(random_word());
    repeat (fifo_depth + 1)
      host_read();
    // Mixed traffic that fills up over time
    repeat (6)
    begin
      host_write(random_word());
      host_write(random_word());
      host_read();
    end
    repeat (fifo_depth + 1)
      host_read();
  endtask

  task automatic test_hcr();
    logic [data_w-1:0] w;
    logic [31:0]       r;
    sysio_dbg_mask = '0;
    mask_m         = '0;
    for (int c = 0; c < num_cores; c++)
    begin
      load_ir(reg_code_hcr, c);
      host_write(random_word());
      host_read();
    end
    // Every core keeps its own value
    for (int c = 0; c < num_cores; c++)
    begin
      load_ir(reg_code_hcr, c);
      host_read();
    end
    // Request bit set on all cores
    for (int c = 0; c < num_cores; c++)
    begin
      load_ir(reg_code_hcr, c);
      w = random_word();
      w[hcr_dbg_req_bit] = 1'b1;
      host_write(w);
      host_read();
    end
    // Mask moving under live requests
    repeat (10)
    begin
      r = $random(seed);
      sysio_dbg_mask = r[num_cores-1:0];
      mask_m         = r[num_cores-1:0];
      idle_cycles(2);
    end
    sysio_dbg_mask = '0;
    mask_m         = '0;
    for (int c = 0; c < num_cores; c++)
    begin
      load_ir(reg_code_hcr, c);
      host_write('0);
      host_read();
    end
    idle_cycles(2);
  endtask

  //========================================
  // Main sequence
  //========================================
  initial
  begin
    seed           = 81;
    fail_count     = 0;
    core0_rst_b    = 1'b0;
    host_ir_wr     = 1'b0;
    host_ir        = '0;
    host_wr        = 1'b0;
    host_rd        = 1'b0;
    host_wdata     = '0;
    sysio_dbg_mask = '0;
    core_rst_b     = '1;
    ir_m           = '0;
    mask_m         = '0;
    stat_m         = '0;
    for (int i = 0; i < num_cores; i++)
      hcr_m[i] = '0;
    fifo_m.delete();

    // Reset held for 16 cycles
    repeat (16) @(posedge forever_cpuclk);
    #2;
    core0_rst_b = 1'b1;
    idle_cycles(2);

    test_id();
    test_rst_status();
    test_mask();
    test_fifo();
    test_hcr();
    idle_cycles(4);

    if (fail_count == 0)
    begin
      $display("Simulation completed successfully");
      $finish;
    end
    else
      abort_run();
  end

endmodule

`default_nettype wire

/* project.f */
had_pkg.sv
had_ir_decode.sv
had_core_dbg.sv
had_dbg_fifo.sv
had_common_regs.sv
had_top.sv
tb_had_top.sv

/* Makefile */
# Verilator build and run of the debug register block testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal --top-module tb_had_top -f project.f -Mdir obj_dir
	-./obj_dir/Vtb_had_top > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || \
		{ echo "TEST FAILED, see $(LOG)"; exit 1; }
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir $(LOG)
